/* src/uart_pkg.sv */
package uart_pkg;

    localparam int CLK_FREQ  = 25_000_000;
    localparam int BAUD_RATE = 1_562_500;
    localparam int BAUD_DIV  = CLK_FREQ / BAUD_RATE;   // clocks per bit
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);      // baud counter width

    localparam int TX_DEPTH = 4;
    localparam int RX_DEPTH = 4;
    localparam int CREDIT_W = 3;   // holds 0..TX_DEPTH

    // byte-wide register map
    typedef enum logic [1:0] {
        REG_DATA      = 2'd0,
        REG_RX_STATUS = 2'd1,
        REG_TX_STATUS = 2'd2,
        REG_SCRATCH   = 2'd3
    } uart_reg_e;

    // wishbone request from the master
    typedef struct packed {
        logic       stb;
        logic       we;
        uart_reg_e  adr;
        logic [7:0] dat;
    } wb_req_t;

    // wishbone response back to the master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // one received frame
    typedef struct packed {
        logic       frame_err;   // stop bit was low
        logic [7:0] data;
    } rx_entry_t;

endpackage

/* src/uart_fifo.sv */
module uart_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     CLK_I,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    payload_t mem [DEPTH];
    ptr_t     rd_ptr;
    ptr_t     wr_ptr;
    cnt_t     count;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head  = mem[rd_ptr];   // show-ahead
    assign empty = (count == '0);
    assign full  = (count == cnt_t'(DEPTH));

    // users never push when full or pop when empty
    always_ff @(posedge CLK_I) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK_I) begin
        if (push) mem[wr_ptr] <= push_data;
    end

endmodule

/* src/uart_tx.sv */
module uart_tx (
    input  logic       CLK_I,
    input  logic       rst_n,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_head,
    output logic       pop,
    output logic       tx,
    output logic       idle
);
    import uart_pkg::*;

    typedef enum logic {S_IDLE, S_SEND} state_e;

    state_e                state;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;    // 0 start, 1..8 data, 9 stop
    logic [7:0]            shreg;
    logic                  bit_end;
    logic                  frame_end;

    assign bit_end   = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
    assign frame_end = bit_end && (bit_cnt == 4'd9);

    // take the next byte when idle, or straight after a stop bit
    assign pop  = !fifo_empty && (state == S_IDLE || (state == S_SEND && frame_end));
    assign idle = (state == S_IDLE);

    always_ff @(posedge CLK_I) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            tx       <= 1'b1;   // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (pop) begin
            state    <= S_SEND;
            tx       <= 1'b0;   // start bit
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == S_SEND) begin
            if (bit_end) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    state <= S_IDLE;
                end else begin
                    tx      <= shreg[0];   // lsb first then the ones that form the stop bit
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (pop) begin
            shreg <= fifo_head;
        end else if (state == S_SEND && bit_end && !frame_end) begin
            shreg <= {1'b1, shreg[7:1]};
        end
    end

endmodule

/* src/uart_rx.sv */
module uart_rx (
    input  logic                CLK_I,
    input  logic                rst_n,
    input  logic                rx,
    input  logic                fifo_full,
    output logic                push,
    output uart_pkg::rx_entry_t push_data,
    output logic                overrun
);
    import uart_pkg::*;

    typedef enum logic {S_IDLE, S_RECV} state_e;

    state_e                state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [2:0]            filt;       // previous three synced samples
    logic                  armed;      // line seen high while idle
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic [7:0]            shreg;
    logic                  start_det;
    logic                  mid_bit;

    assign start_det = (state == S_IDLE) && armed && ({rx_sync, filt} == 4'b0000);
    assign mid_bit   = (state == S_RECV) && (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2));

    always_ff @(posedge CLK_I) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            filt    <= 3'b111;
            armed   <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            filt    <= {rx_sync, filt[2:1]};
            if (start_det)
                armed <= 1'b0;
            else if (state == S_IDLE && rx_sync)
                armed <= 1'b1;   // a low stop bit cannot retrigger
        end
    end

    always_ff @(posedge CLK_I) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            push     <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            push    <= 1'b0;
            overrun <= 1'b0;
            if (start_det) begin
                state    <= S_RECV;
                baud_cnt <= BAUD_CNT_W'(4);   // four low samples already seen
                bit_cnt  <= '0;
            end else if (state == S_RECV) begin
                if (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1))
                    baud_cnt <= '0;
                else
                    baud_cnt <= baud_cnt + 1'b1;
                if (mid_bit) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'd0 && rx_sync) begin
                        state <= S_IDLE;   // glitch rather than a start bit
                    end else if (bit_cnt == 4'd9) begin
                        state <= S_IDLE;
                        if (fifo_full)
                            overrun <= 1'b1;
                        else
                            push <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (mid_bit && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shreg <= {rx_sync, shreg[7:1]};   // lsb arrives first
        if (mid_bit && bit_cnt == 4'd9) begin
            push_data.frame_err <= !rx_sync;
            push_data.data      <= shreg;
        end
    end

endmodule

/* src/uart_wb_ctrl.sv */
module uart_wb_ctrl (
    input  logic                CLK_I,
    input  logic                rst_n,
    input  uart_pkg::wb_req_t   wb_req,
    output uart_pkg::wb_rsp_t   wb_rsp,
    output logic                tx_push,
    output logic [7:0]          tx_data,
    input  logic                tx_pop,
    input  logic                tx_idle,
    input  logic                tx_empty,
    input  uart_pkg::rx_entry_t rx_head,
    input  logic                rx_empty,
    output logic                rx_pop,
    input  logic                rx_overrun
);
    import uart_pkg::*;

    logic                ack_q;
    logic [7:0]          dat_q;
    logic [7:0]          scratch;
    logic [7:0]          rx_status;
    logic [7:0]          tx_status;
    logic [7:0]          rd_data;
    logic [CREDIT_W-1:0] credits;
    logic                pop_q;        // credit comes back a cycle after the pop
    logic                overrun_q;
    logic                overflow_q;
    logic                access;
    logic                rd;
    logic                wr;
    logic                data_wr;
    logic                drop;

    // one access per strobe without wait states
    assign access  = wb_req.stb && !ack_q;
    assign rd      = access && !wb_req.we;
    assign wr      = access && wb_req.we;
    assign data_wr = wr && (wb_req.adr == REG_DATA);

    assign tx_push = data_wr && (credits != '0);
    assign drop    = data_wr && (credits == '0);   // no room so the byte is lost
    assign tx_data = wb_req.dat;
    assign rx_pop  = rd && (wb_req.adr == REG_DATA) && !rx_empty;

    assign rx_status = {5'b0, overrun_q, rx_head.frame_err & ~rx_empty, ~rx_empty};
    assign tx_status = {1'b0, credits, 2'b0, overflow_q, tx_idle & tx_empty};

    always_comb begin
        case (wb_req.adr)
            REG_DATA:      rd_data = rx_empty ? 8'h00 : rx_head.data;
            REG_RX_STATUS: rd_data = rx_status;
            REG_TX_STATUS: rd_data = tx_status;
            default:       rd_data = scratch;
        endcase
    end

    always_ff @(posedge CLK_I) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            pop_q      <= 1'b0;
            credits    <= CREDIT_W'(TX_DEPTH);
            overrun_q  <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            ack_q <= access;
            pop_q <= tx_pop;
            case ({tx_push, pop_q})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // sticky until the status byte that shows it is read
            overrun_q  <= rx_overrun ||
                          (overrun_q && !(rd && wb_req.adr == REG_RX_STATUS));
            overflow_q <= drop ||
                          (overflow_q && !(rd && wb_req.adr == REG_TX_STATUS));
        end
    end

    always_ff @(posedge CLK_I) begin
        if (access)
            dat_q <= rd ? rd_data : 8'h00;
        if (wr && wb_req.adr == REG_SCRATCH)
            scratch <= wb_req.dat;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

/* src/uart_wb8.sv */
module uart_wb8 (
    input  logic              CLK_I,
    input  logic              rst_n,
    input  uart_pkg::wb_req_t wb_req,
    output uart_pkg::wb_rsp_t wb_rsp,
    input  logic              rx,
    output logic              tx
);
    import uart_pkg::*;

    logic       tx_push;
    logic [7:0] tx_data;
    logic       tx_pop;
    logic [7:0] tx_head;
    logic       tx_empty;
    logic       tx_idle;

    rx_entry_t  rx_push_data;
    rx_entry_t  rx_head;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_empty;
    logic       rx_full;
    logic       rx_overrun;

    uart_wb_ctrl u_ctrl (
        .CLK_I      (CLK_I),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .tx_push    (tx_push),
        .tx_data    (tx_data),
        .tx_pop     (tx_pop),
        .tx_idle    (tx_idle),
        .tx_empty   (tx_empty),
        .rx_head    (rx_head),
        .rx_empty   (rx_empty),
        .rx_pop     (rx_pop),
        .rx_overrun (rx_overrun)
    );

    // credits keep this one from filling past its depth
    uart_fifo #(.payload_t(logic [7:0]), .DEPTH(TX_DEPTH)) u_tx_fifo (
        .CLK_I     (CLK_I),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .empty     (tx_empty),
        .full      ()
    );

    uart_tx u_tx (
        .CLK_I      (CLK_I),
        .rst_n      (rst_n),
        .fifo_empty (tx_empty),
        .fifo_head  (tx_head),
        .pop        (tx_pop),
        .tx         (tx),
        .idle       (tx_idle)
    );

    uart_rx u_rx (
        .CLK_I     (CLK_I),
        .rst_n     (rst_n),
        .rx        (rx),
        .fifo_full (rx_full),
        .push      (rx_push),
        .push_data (rx_push_data),
        .overrun   (rx_overrun)
    );

    uart_fifo #(.payload_t(rx_entry_t), .DEPTH(RX_DEPTH)) u_rx_fifo (
        .CLK_I     (CLK_I),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_pop),
        .head      (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

endmodule

/* tests/uart_wb8_properties.sv */
module uart_wb8_properties (
    input logic                          CLK_I,
    input logic                          rst_n,
    input logic                          stb,
    input logic                          ack,
    input logic [uart_pkg::CREDIT_W-1:0] credits,
    input logic                          tx_idle,
    input logic                          tx_empty,
    input logic                          rx_overrun,
    input logic                          rx_empty
);
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    // master releases the strobe once it sees ack
    stb_dropped_on_ack: assert property (@(posedge CLK_I) disable iff (!rst_n) ack |-> !stb)
        else $error("wishbone strobe not dropped in the ack cycle");

    credits_bounded: assert property (@(posedge CLK_I) disable iff (!rst_n)
        credits <= CREDIT_W'(TX_DEPTH))
        else $error("transmit credits above the fifo depth");

    // every credit is back when the transmit path has drained
    credits_home_when_idle: assert property (@(posedge CLK_I) disable iff (!rst_n)
        tx_idle && tx_empty |-> credits == CREDIT_W'(TX_DEPTH))
        else $error("transmit credits missing while the transmitter is idle");

    overrun_needs_data: assert property (@(posedge CLK_I) disable iff (!rst_n)
        rx_overrun |-> !rx_empty)
        else $error("receive overrun flagged while the fifo is empty");

endmodule

bind uart_wb_ctrl uart_wb8_properties u_props (
    .CLK_I      (CLK_I),
    .rst_n      (rst_n),
    .stb        (wb_req.stb),
    .ack        (wb_rsp.ack),
    .credits    (credits),
    .tx_idle    (tx_idle),
    .tx_empty   (tx_empty),
    .rx_overrun (rx_overrun),
    .rx_empty   (rx_empty)
);

/* tests/tb_uart_wb8.sv */
module tb_uart_wb8;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    localparam int FRAME_CYCLES = 10 * BAUD_DIV;
    localparam int MAX_CYCLES   = 3 * 40 * FRAME_CYCLES + 800;   // 40 frames plus slack
    localparam int POLL_LIMIT   = 64;
    localparam int LOOP_POLLS   = 2000;
    localparam int LOOP_BYTES   = 16;

    logic    CLK_I;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    rx_drv;
    logic    loopback;
    logic    rx;
    logic    tx;
    int      mismatches;
    int      protocol_errors;
    int      seed;
    string   test_name;

    assign rx = loopback ? tx : rx_drv;

    uart_wb8 dut (
        .CLK_I  (CLK_I),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .rx     (rx),
        .tx     (tx)
    );

    initial begin
        CLK_I = 1'b0;
        forever #4 CLK_I = ~CLK_I;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge CLK_I);
        $display("timeout: the run was still going after %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic wb_rsp_t acked(input logic [7:0] dat);
        wb_rsp_t r;
        r.ack = 1'b1;
        r.dat = dat;
        return r;
    endfunction

    function automatic rx_entry_t make_entry(input logic ferr, input logic [7:0] data);
        rx_entry_t e;
        e.frame_err = ferr;
        e.data      = data;
        return e;
    endfunction

    // status layouts from the register map
    function automatic logic [7:0] rx_status_byte(input logic avail, input logic ferr,
                                                  input logic ovr);
        return {5'b0, ovr, ferr, avail};
    endfunction

    function automatic logic [7:0] tx_status_byte(input int credits, input logic ovf,
                                                  input logic idle);
        return {1'b0, 3'(credits), 2'b00, ovf, idle};
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected rsp %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_entry(input string name, input rx_entry_t exp, input rx_entry_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected entry %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic wb_access(input logic we, input uart_reg_e adr, input logic [7:0] dat,
                             output wb_rsp_t rsp);
        int cycles;
        @(posedge CLK_I);
        #1;
        if (wb_rsp.ack) begin
            $display("%s: wishbone ack stayed high past its cycle", test_name);
            protocol_errors++;
        end
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        cycles = 0;
        do begin
            @(posedge CLK_I);
            #1;
            cycles++;
        end while (!wb_rsp.ack);
        if (cycles != 1) begin
            $display("%s: wishbone ack took %0d cycles instead of one", test_name, cycles);
            protocol_errors++;
        end
        rsp = wb_rsp;
        wb_req.stb = 1'b0;   // dropped in the ack cycle
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input uart_reg_e adr, input logic [7:0] dat);
        wb_rsp_t rsp;
        wb_access(1'b1, adr, dat, rsp);
        check_rsp(test_name, acked(8'h00), rsp);
    endtask

    task automatic wb_read(input uart_reg_e adr, output wb_rsp_t rsp);
        wb_access(1'b0, adr, 8'h00, rsp);
    endtask

    task automatic wait_rx_ready(output wb_rsp_t status);
        int polls;
        polls = 0;
        do begin
            wb_read(REG_RX_STATUS, status);
            polls++;
        end while (!status.dat[0] && polls < POLL_LIMIT);
        if (!status.dat[0]) begin
            $display("%s: receive data never became available", test_name);
            protocol_errors++;
        end
    endtask

    task automatic wait_tx_idle(output wb_rsp_t status);
        int polls;
        polls = 0;
        do begin
            wb_read(REG_TX_STATUS, status);
            polls++;
        end while (!status.dat[0] && polls < POLL_LIMIT);
        if (!status.dat[0]) begin
            $display("%s: transmitter never went idle", test_name);
            protocol_errors++;
        end
    endtask

    task automatic serial_send(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};   // start bit goes out first
        @(posedge CLK_I);
        #1;
        for (int i = 0; i < 10; i++) begin
            rx_drv = frame[i];
            repeat (BAUD_DIV) @(posedge CLK_I);
            #1;
        end
        rx_drv = 1'b1;
    endtask

    task automatic serial_expect(input logic [7:0] exp);
        logic [7:0] got;
        int         waited;
        got    = '0;
        waited = 0;
        @(posedge CLK_I);
        #1;
        while (tx !== 1'b0 && waited < 12 * FRAME_CYCLES) begin
            @(posedge CLK_I);
            #1;
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("%s: no start bit on tx within %0d cycles", test_name, waited);
            protocol_errors++;
            return;
        end
        repeat (BAUD_DIV / 2) @(posedge CLK_I);   // to mid-bit
        #1;
        if (tx !== 1'b0) begin
            $display("%s: start bit on tx ended before mid-bit", test_name);
            protocol_errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(posedge CLK_I);
            #1;
            got[i] = tx;
        end
        repeat (BAUD_DIV) @(posedge CLK_I);
        #1;
        if (tx !== 1'b1) begin
            $display("%s: stop bit on tx was low", test_name);
            protocol_errors++;
        end
        check_byte(test_name, exp, got);
    endtask

    task automatic reset_state();
        wb_rsp_t rsp;
        test_name = "reset";
        check_byte(test_name, 8'h01, {7'b0, tx});
        wb_read(REG_RX_STATUS, rsp);
        check_rsp(test_name, acked(rx_status_byte(1'b0, 1'b0, 1'b0)), rsp);
        wb_read(REG_TX_STATUS, rsp);
        check_rsp(test_name, acked(tx_status_byte(TX_DEPTH, 1'b0, 1'b1)), rsp);
        wb_write(REG_SCRATCH, 8'hA5);
        wb_read(REG_SCRATCH, rsp);
        check_rsp(test_name, acked(8'hA5), rsp);
        wb_write(REG_SCRATCH, 8'h3C);
        wb_read(REG_SCRATCH, rsp);
        check_rsp(test_name, acked(8'h3C), rsp);
        check_byte(test_name, 8'h01, {7'b0, tx});   // line still idle
    endtask

    task automatic single_transmit();
        wb_rsp_t rsp;
        test_name = "single transmit";
        fork
            wb_write(REG_DATA, 8'hB4);
            serial_expect(8'hB4);
        join
        wait_tx_idle(rsp);
        check_byte(test_name, tx_status_byte(TX_DEPTH, 1'b0, 1'b1), rsp.dat);
    endtask

    task automatic receive_with_errors();
        wb_rsp_t status;
        wb_rsp_t rsp;
        test_name = "receive";
        serial_send(8'h5A, 1'b1);
        wait_rx_ready(status);
        check_byte(test_name, rx_status_byte(1'b1, 1'b0, 1'b0), status.dat);
        wb_read(REG_DATA, rsp);
        check_entry(test_name, make_entry(1'b0, 8'h5A), make_entry(status.dat[1], rsp.dat));
        wb_read(REG_RX_STATUS, rsp);
        check_byte(test_name, rx_status_byte(1'b0, 1'b0, 1'b0), rsp.dat);

        test_name = "receive frame error";
        serial_send(8'hC3, 1'b0);
        wait_rx_ready(status);
        check_byte(test_name, rx_status_byte(1'b1, 1'b1, 1'b0), status.dat);
        wb_read(REG_DATA, rsp);
        check_entry(test_name, make_entry(1'b1, 8'hC3), make_entry(status.dat[1], rsp.dat));
        wb_read(REG_RX_STATUS, rsp);
        check_byte(test_name, rx_status_byte(1'b0, 1'b0, 1'b0), rsp.dat);
    endtask

    task automatic credit_exhaustion();
        logic [7:0] data [TX_DEPTH + 2];
        wb_rsp_t    rsp;
        test_name = "credit exhaustion";
        for (int i = 0; i < TX_DEPTH + 2; i++)
            data[i] = 8'($random(seed));
        fork
            begin
                for (int i = 0; i < TX_DEPTH + 2; i++)
                    wb_write(REG_DATA, data[i]);
                wb_read(REG_TX_STATUS, rsp);   // last byte dropped
                check_byte(test_name, tx_status_byte(0, 1'b1, 1'b0), rsp.dat);
                wb_read(REG_TX_STATUS, rsp);
                check_byte(test_name, tx_status_byte(0, 1'b0, 1'b0), rsp.dat);
            end
            begin
                for (int i = 0; i < TX_DEPTH + 1; i++)
                    serial_expect(data[i]);
            end
        join
        wait_tx_idle(rsp);   // nothing else queued once idle with the fifo empty
        check_byte(test_name, tx_status_byte(TX_DEPTH, 1'b0, 1'b1), rsp.dat);
    endtask

    task automatic receive_overrun();
        logic [7:0] data [RX_DEPTH + 1];
        wb_rsp_t    status;
        wb_rsp_t    rsp;
        test_name = "receive overrun";
        for (int i = 0; i < RX_DEPTH + 1; i++)
            data[i] = 8'($random(seed));
        for (int i = 0; i < RX_DEPTH + 1; i++)
            serial_send(data[i], 1'b1);
        wait_rx_ready(status);
        check_byte(test_name, rx_status_byte(1'b1, 1'b0, 1'b1), status.dat);
        for (int i = 0; i < RX_DEPTH; i++) begin
            wait_rx_ready(status);
            wb_read(REG_DATA, rsp);
            check_entry(test_name, make_entry(1'b0, data[i]),
                        make_entry(status.dat[1], rsp.dat));
        end
        wb_read(REG_RX_STATUS, rsp);
        check_byte(test_name, rx_status_byte(1'b0, 1'b0, 1'b0), rsp.dat);
    endtask

    task automatic random_loopback();
        logic [7:0] data [LOOP_BYTES];
        wb_rsp_t    status;
        wb_rsp_t    rsp;
        int         sent;
        int         got;
        int         credits;
        int         polls;
        test_name = "random loopback";
        for (int i = 0; i < LOOP_BYTES; i++)
            data[i] = 8'($random(seed));
        sent     = 0;
        got      = 0;
        polls    = 0;
        loopback = 1'b1;
        while (got < LOOP_BYTES && polls < LOOP_POLLS) begin
            wb_read(REG_TX_STATUS, status);
            credits = int'(status.dat[6:4]);
            while (credits > 0 && sent < LOOP_BYTES) begin
                wb_write(REG_DATA, data[sent]);
                sent++;
                credits--;
            end
            wb_read(REG_RX_STATUS, status);
            if (status.dat[0]) begin
                check_byte(test_name, rx_status_byte(1'b1, 1'b0, 1'b0), status.dat);
                wb_read(REG_DATA, rsp);
                check_entry(test_name, make_entry(1'b0, data[got]),
                            make_entry(status.dat[1], rsp.dat));
                got++;
            end
            polls++;
        end
        if (got < LOOP_BYTES) begin
            $display("%s: only %0d of %0d bytes came back", test_name, got, LOOP_BYTES);
            protocol_errors++;
        end
        loopback = 1'b0;
    endtask

    initial begin
        seed            = 88353;
        mismatches      = 0;
        protocol_errors = 0;
        test_name       = "init";
        wb_req          = '0;
        rx_drv          = 1'b1;
        loopback        = 1'b0;
        rst_n           = 1'b0;
        repeat (8) @(posedge CLK_I);
        #1;
        rst_n = 1'b1;

        reset_state();
        single_transmit();
        receive_with_errors();
        credit_exhaustion();
        receive_overrun();
        random_loopback();

        $display("errors: %0d value mismatches, %0d protocol errors",
                 mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_wb_ctrl.sv
src/uart_wb8.sv
tests/uart_wb8_properties.sv
tests/tb_uart_wb8.sv

/* Makefile */
# Verilator flow for the Wishbone UART

VERILATOR ?= verilator
TOP       ?= tb_uart_wb8
RTL_TOP   ?= uart_wb8
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := $(filter src/%.sv,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
